/* design/isaPkg.sv */
package isaPkg;

    typedef logic [63:0] xlenT;
    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  funct3T;
    typedef logic [6:0]  funct7T;
    typedef logic [3:0]  aluOpT;
    typedef logic [2:0]  immFmtT;
    typedef logic [3:0]  brKindT; // conditional kinds carry funct3 under a set msb
    typedef logic [2:0]  memOpT;

    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opOpImm  = 7'b0010011;
    localparam opcodeT opAuipc  = 7'b0010111;
    localparam opcodeT opOpImmW = 7'b0011011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opOp     = 7'b0110011;
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opOpW    = 7'b0111011;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opJal    = 7'b1101111;

    localparam aluOpT aluAdd   = 4'd0;
    localparam aluOpT aluSub   = 4'd1;
    localparam aluOpT aluSll   = 4'd2;
    localparam aluOpT aluSrl   = 4'd3;
    localparam aluOpT aluSra   = 4'd4;
    localparam aluOpT aluXor   = 4'd5;
    localparam aluOpT aluOr    = 4'd6;
    localparam aluOpT aluAnd   = 4'd7;
    localparam aluOpT aluSlt   = 4'd8;
    localparam aluOpT aluSltu  = 4'd9;
    localparam aluOpT aluPassB = 4'd10; // lui

    localparam immFmtT immNone = 3'd0;
    localparam immFmtT immI    = 3'd1;
    localparam immFmtT immS    = 3'd2;
    localparam immFmtT immB    = 3'd3;
    localparam immFmtT immU    = 3'd4;
    localparam immFmtT immJ    = 3'd5;

    localparam brKindT brNone = 4'b0000;
    localparam brKindT brJal  = 4'b0001;
    localparam brKindT brJalr = 4'b0010;
    localparam brKindT brEq   = 4'b1000;
    localparam brKindT brNe   = 4'b1001;
    localparam brKindT brLt   = 4'b1100;
    localparam brKindT brGe   = 4'b1101;
    localparam brKindT brLtu  = 4'b1110;
    localparam brKindT brGeu  = 4'b1111;

    localparam memOpT memNone = 3'd0;
    localparam memOpT memB    = 3'd1;
    localparam memOpT memH    = 3'd2;
    localparam memOpT memW    = 3'd3;
    localparam memOpT memD    = 3'd4;
    localparam memOpT memBu   = 3'd5;
    localparam memOpT memHu   = 3'd6;
    localparam memOpT memWu   = 3'd7;

endpackage

/* design/pipePkg.sv */
package pipePkg;
    import isaPkg::*;

    typedef logic [1:0] srcBSelT;

    localparam srcBSelT srcBImm  = 2'd0;
    localparam srcBSelT srcBRs2  = 2'd1;
    localparam srcBSelT srcBFour = 2'd2; // link address for jal/jalr

    typedef struct packed {
        xlenT pc;
        wordT inst;
        xlenT rs1Val;
        xlenT rs2Val;
    } issuePktT;

    typedef struct packed {
        aluOpT   aluOp;
        logic    srcAIsPc;
        srcBSelT srcBSel;
        brKindT  brKind;
        logic    memWr;
        memOpT   memOp;
        logic    memToReg;
        logic    regWr;
        logic    isWord;
        logic    illegal;
    } ctrlT;

    typedef struct packed {
        ctrlT   ctrl;
        xlenT   imm;
        xlenT   pc;
        xlenT   rs1Val;
        xlenT   rs2Val;
        regIdxT rd;
    } decPktT;

    typedef struct packed {
        ctrlT   ctrl;
        xlenT   aluOut;
        xlenT   rs2Val;
        regIdxT rd;
        xlenT   nextPc;
        logic   branchTaken;
    } exePktT;

    typedef struct packed {
        regIdxT rd;
        xlenT   wbData;
        logic   wbEn;
        logic   memWr;
        memOpT  memOp;
        xlenT   memAddr;
        xlenT   storeData;
        logic   branchTaken;
        xlenT   nextPc;
        logic   illegal;
    } resultPktT;

endpackage

/* design/instDecoder.sv */
module instDecoder (
    input  logic              clk,
    input  logic              arstN,
    input  logic              inValid,
    output logic              inReady,
    input  pipePkg::issuePktT inPkt,
    output logic              decValid,
    output pipePkg::decPktT   decPkt,
    input  logic              nextReady
);
    import isaPkg::*;
    import pipePkg::*;

    opcodeT opcode;
    funct3T funct3;
    funct7T funct7;
    aluOpT  aluOp;
    immFmtT immFmt;
    memOpT  memKind;
    logic   known;
    ctrlT   ctrl;
    xlenT   imm;
    logic   started;
    logic   accept;

    assign opcode = inPkt.inst[6:0];
    assign funct3 = inPkt.inst[14:12];
    assign funct7 = inPkt.inst[31:25];

    // alu operation and legality from the full encoding
    always_comb begin
        aluOp = aluAdd;
        known = 1'b1;
        casez ({funct7, funct3, opcode})
            {7'b???????, 3'b???, opLui}: aluOp = aluPassB;
            {7'b???????, 3'b???, opAuipc},
            {7'b???????, 3'b???, opJal},
            {7'b???????, 3'b000, opJalr},
            {7'b???????, 3'b0??, opLoad},
            {7'b???????, 3'b10?, opLoad},
            {7'b???????, 3'b110, opLoad},
            {7'b???????, 3'b0??, opStore},
            {7'b???????, 3'b00?, opBranch},
            {7'b???????, 3'b1??, opBranch},
            {7'b???????, 3'b000, opOpImm},
            {7'b???????, 3'b000, opOpImmW},
            {7'b0000000, 3'b000, opOp},
            {7'b0000000, 3'b000, opOpW}: aluOp = aluAdd;
            {7'b0100000, 3'b000, opOp},
            {7'b0100000, 3'b000, opOpW}: aluOp = aluSub;
            {7'b0000000, 3'b001, opOp},
            {7'b0000000, 3'b001, opOpW},
            {7'b000000?, 3'b001, opOpImm}, // funct7[0] is shamt[5]
            {7'b0000000, 3'b001, opOpImmW}: aluOp = aluSll;
            {7'b0000000, 3'b010, opOp},
            {7'b???????, 3'b010, opOpImm}: aluOp = aluSlt;
            {7'b0000000, 3'b011, opOp},
            {7'b???????, 3'b011, opOpImm}: aluOp = aluSltu;
            {7'b0000000, 3'b100, opOp},
            {7'b???????, 3'b100, opOpImm}: aluOp = aluXor;
            {7'b0000000, 3'b101, opOp},
            {7'b0000000, 3'b101, opOpW},
            {7'b000000?, 3'b101, opOpImm},
            {7'b0000000, 3'b101, opOpImmW}: aluOp = aluSrl;
            {7'b0100000, 3'b101, opOp},
            {7'b0100000, 3'b101, opOpW},
            {7'b010000?, 3'b101, opOpImm},
            {7'b0100000, 3'b101, opOpImmW}: aluOp = aluSra;
            {7'b0000000, 3'b110, opOp},
            {7'b???????, 3'b110, opOpImm}: aluOp = aluOr;
            {7'b0000000, 3'b111, opOp},
            {7'b???????, 3'b111, opOpImm}: aluOp = aluAnd;
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  memKind = memB;
            3'b001:  memKind = memH;
            3'b010:  memKind = memW;
            3'b011:  memKind = memD;
            3'b100:  memKind = memBu;
            3'b101:  memKind = memHu;
            3'b110:  memKind = memWu;
            default: memKind = memNone;
        endcase
    end

    always_comb begin
        ctrl         = '0;
        ctrl.aluOp   = aluOp;
        ctrl.srcBSel = srcBImm;
        ctrl.brKind  = brNone;
        ctrl.memOp   = memNone;
        immFmt       = immNone;
        case (opcode)
            opLui, opAuipc: begin
                immFmt        = immU;
                ctrl.srcAIsPc = 1'b1;
                ctrl.regWr    = 1'b1;
            end
            opJal, opJalr: begin
                immFmt        = (opcode == opJal) ? immJ : immI;
                ctrl.srcAIsPc = 1'b1; // link value pc+4
                ctrl.srcBSel  = srcBFour;
                ctrl.brKind   = (opcode == opJal) ? brJal : brJalr;
                ctrl.regWr    = 1'b1;
            end
            opBranch: begin
                immFmt       = immB;
                ctrl.srcBSel = srcBRs2;
                ctrl.brKind  = {1'b1, funct3};
            end
            opLoad: begin
                immFmt        = immI;
                ctrl.memOp    = memKind;
                ctrl.memToReg = 1'b1;
                ctrl.regWr    = 1'b1;
            end
            opStore: begin
                immFmt     = immS;
                ctrl.memOp = memKind;
                ctrl.memWr = 1'b1;
            end
            opOpImm, opOpImmW: begin
                immFmt      = immI;
                ctrl.regWr  = 1'b1;
                ctrl.isWord = (opcode == opOpImmW);
            end
            opOp, opOpW: begin
                ctrl.srcBSel = srcBRs2;
                ctrl.regWr   = 1'b1;
                ctrl.isWord  = (opcode == opOpW);
            end
            default: ;
        endcase
        if (!known) begin
            ctrl.brKind   = brNone;
            ctrl.memOp    = memNone;
            ctrl.memWr    = 1'b0;
            ctrl.memToReg = 1'b0;
            ctrl.regWr    = 1'b0;
            ctrl.illegal  = 1'b1;
        end
    end

    always_comb begin
        case (immFmt)
            immI: imm = {{52{inPkt.inst[31]}}, inPkt.inst[31:20]};
            immS: imm = {{52{inPkt.inst[31]}}, inPkt.inst[31:25], inPkt.inst[11:7]};
            immB: imm = {{51{inPkt.inst[31]}}, inPkt.inst[31], inPkt.inst[7],
                         inPkt.inst[30:25], inPkt.inst[11:8], 1'b0};
            immU: imm = {{32{inPkt.inst[31]}}, inPkt.inst[31:12], 12'b0};
            immJ: imm = {{43{inPkt.inst[31]}}, inPkt.inst[31], inPkt.inst[19:12],
                         inPkt.inst[20], inPkt.inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    assign inReady = started && (!decValid || nextReady);
    assign accept  = inValid && inReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            started  <= 1'b0;
            decValid <= 1'b0;
        end else begin
            started <= 1'b1; // ready from the first cycle after reset
            if (inReady) begin
                decValid <= inValid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            decPkt <= '{ctrl: ctrl, imm: imm, pc: inPkt.pc, rs1Val: inPkt.rs1Val,
                        rs2Val: inPkt.rs2Val, rd: inPkt.inst[11:7]};
        end
    end

endmodule

/* design/aluExec.sv */
module aluExec (
    input  logic            clk,
    input  logic            arstN,
    input  logic            decValid,
    input  pipePkg::decPktT decPkt,
    output logic            exeReady,
    output logic            exeValid,
    output pipePkg::exePktT exePkt,
    input  logic            nextReady
);
    import isaPkg::*;
    import pipePkg::*;

    xlenT       opA;
    xlenT       opB;
    logic [5:0] shamt;
    logic [31:0] srlWord;
    logic [31:0] sraWord;
    xlenT       sraLong;
    xlenT       aluOut;
    logic       isEq;
    logic       isLt;
    logic       isLtu;
    logic       taken;
    xlenT       nextPc;

    assign opA = decPkt.ctrl.srcAIsPc ? decPkt.pc : decPkt.rs1Val;

    always_comb begin
        case (decPkt.ctrl.srcBSel)
            srcBRs2:  opB = decPkt.rs2Val;
            srcBFour: opB = 64'd4;
            default:  opB = decPkt.imm;
        endcase
    end

    assign shamt   = decPkt.ctrl.isWord ? {1'b0, opB[4:0]} : opB[5:0];
    assign srlWord = opA[31:0] >> shamt[4:0];
    assign sraWord = $signed(opA[31:0]) >>> shamt[4:0];
    assign sraLong = $signed(opA) >>> shamt;

    always_comb begin
        case (decPkt.ctrl.aluOp)
            aluSub:   aluOut = opA - opB;
            aluSll:   aluOut = opA << shamt;
            aluSrl:   aluOut = decPkt.ctrl.isWord ? {32'b0, srlWord} : opA >> shamt;
            aluSra:   aluOut = decPkt.ctrl.isWord ? {32'b0, sraWord} : sraLong;
            aluXor:   aluOut = opA ^ opB;
            aluOr:    aluOut = opA | opB;
            aluAnd:   aluOut = opA & opB;
            aluSlt:   aluOut = {63'b0, $signed(opA) < $signed(opB)};
            aluSltu:  aluOut = {63'b0, opA < opB};
            aluPassB: aluOut = opB;
            default:  aluOut = opA + opB;
        endcase
    end

    assign isEq  = (decPkt.rs1Val == decPkt.rs2Val);
    assign isLt  = ($signed(decPkt.rs1Val) < $signed(decPkt.rs2Val));
    assign isLtu = (decPkt.rs1Val < decPkt.rs2Val);

    always_comb begin
        case (decPkt.ctrl.brKind)
            brJal, brJalr: taken = 1'b1;
            brEq:          taken = isEq;
            brNe:          taken = !isEq;
            brLt:          taken = isLt;
            brGe:          taken = !isLt;
            brLtu:         taken = isLtu;
            brGeu:         taken = !isLtu;
            default:       taken = 1'b0;
        endcase
    end

    always_comb begin
        if (decPkt.ctrl.brKind == brJalr) begin
            nextPc = (decPkt.rs1Val + decPkt.imm) & ~64'd1;
        end else if (taken) begin
            nextPc = decPkt.pc + decPkt.imm;
        end else begin
            nextPc = decPkt.pc + 64'd4;
        end
    end

    assign exeReady = !exeValid || nextReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exeValid <= 1'b0;
        end else if (exeReady) begin
            exeValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (decValid && exeReady) begin
            exePkt <= '{ctrl: decPkt.ctrl, aluOut: aluOut, rs2Val: decPkt.rs2Val,
                        rd: decPkt.rd, nextPc: nextPc, branchTaken: taken};
        end
    end

endmodule

/* design/resultStage.sv */
module resultStage #(
    parameter int OutCredits = 4
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               exeValid,
    input  pipePkg::exePktT    exePkt,
    output logic               resReady,
    input  logic               creditReturn,
    output logic               outValid,
    output pipePkg::resultPktT outPkt
);
    import isaPkg::*;
    import pipePkg::*;

    localparam int CntW = $clog2(OutCredits + 1);

    logic [CntW-1:0] creditCnt;
    logic            slotFull;
    logic            isMem;
    xlenT            shaped;
    resultPktT       res;

    // word ops keep the low half sign-extended
    assign shaped = exePkt.ctrl.isWord ? {{32{exePkt.aluOut[31]}}, exePkt.aluOut[31:0]}
                                       : exePkt.aluOut;
    assign isMem  = exePkt.ctrl.memWr || exePkt.ctrl.memToReg;

    always_comb begin
        res.rd          = exePkt.rd;
        res.wbData      = isMem ? '0 : shaped; // load data arrives downstream
        res.wbEn        = exePkt.ctrl.regWr && !exePkt.ctrl.illegal;
        res.memWr       = exePkt.ctrl.memWr && !exePkt.ctrl.illegal;
        res.memOp       = exePkt.ctrl.memOp;
        res.memAddr     = isMem ? exePkt.aluOut : '0;
        res.storeData   = exePkt.ctrl.memWr ? exePkt.rs2Val : '0;
        res.branchTaken = exePkt.branchTaken;
        res.nextPc      = exePkt.nextPc;
        res.illegal     = exePkt.ctrl.illegal;
    end

    assign outValid = slotFull && (creditCnt != '0);
    assign resReady = !slotFull || outValid;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            slotFull <= 1'b0;
        end else if (resReady) begin
            slotFull <= exeValid;
        end
    end

    always_ff @(posedge clk) begin
        if (exeValid && resReady) begin
            outPkt <= res;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            creditCnt <= CntW'(OutCredits);
        end else begin
            case ({outValid, creditReturn})
                2'b10:   creditCnt <= creditCnt - CntW'(1); // send only
                2'b01:   creditCnt <= creditCnt + CntW'(1); // return only
                default: creditCnt <= creditCnt;
            endcase
        end
    end

endmodule

/* design/rvExecUnit.sv */
module rvExecUnit #(
    parameter int OutCredits = 4
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               inValid,
    output logic               inReady,
    input  pipePkg::issuePktT  inPkt,
    input  logic               creditReturn,
    output logic               outValid,
    output pipePkg::resultPktT outPkt
);
    import pipePkg::*;

    logic   decValid;
    decPktT decPkt;
    logic   exeReady;
    logic   exeValid;
    exePktT exePkt;
    logic   resReady;

    instDecoder instDecoder_inst (
        .clk       (clk),
        .arstN     (arstN),
        .inValid   (inValid),
        .inReady   (inReady),
        .inPkt     (inPkt),
        .decValid  (decValid),
        .decPkt    (decPkt),
        .nextReady (exeReady)
    );

    aluExec aluExec_inst (
        .clk       (clk),
        .arstN     (arstN),
        .decValid  (decValid),
        .decPkt    (decPkt),
        .exeReady  (exeReady),
        .exeValid  (exeValid),
        .exePkt    (exePkt),
        .nextReady (resReady)
    );

    resultStage #(
        .OutCredits (OutCredits)
    ) resultStage_inst (
        .clk          (clk),
        .arstN        (arstN),
        .exeValid     (exeValid),
        .exePkt       (exePkt),
        .resReady     (resReady),
        .creditReturn (creditReturn),
        .outValid     (outValid),
        .outPkt       (outPkt)
    );

endmodule

/* bench/tbVectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: inst, pc, rs1Val, rs2Val, wbData, wbEn, memAddr, memOp, memWr,
// nextPc, branchTaken, illegal

typedef struct packed {
    wordT  inst;
    xlenT  pc;
    xlenT  rs1Val;
    xlenT  rs2Val;
    xlenT  wbData;
    logic  wbEn;
    xlenT  memAddr;
    memOpT memOp;
    logic  memWr;
    xlenT  nextPc;
    logic  taken;
    logic  illegal;
} vecT;

localparam logic yes    = 1'b1;
localparam logic no     = 1'b0;
localparam xlenT zero64 = 64'h0;
localparam xlenT negOne = 64'hFFFFFFFFFFFFFFFF;
localparam xlenT rA     = 64'h8000000000000010;

localparam int NumVecs = 39;

localparam vecT vecTable [NumVecs] = '{
    '{32'h002082B3, 64'h1000, rA, 64'h4,
      64'h8000000000000014, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h402082B3, 64'h1000, rA, 64'h4,
      64'h800000000000000C, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h002092B3, 64'h1000, rA, 64'h4,
      64'h0000000000000100, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h0020A2B3, 64'h1000, rA, 64'h4,
      64'h1, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h0020B2B3, 64'h1000, rA, 64'h4,
      64'h0, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h0020C2B3, 64'h1000, rA, 64'h4,
      64'h8000000000000014, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h0020D2B3, 64'h1000, rA, 64'h4,
      64'h0800000000000001, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h4020D2B3, 64'h1000, rA, 64'h4,
      64'hF800000000000001, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h0020E2B3, 64'h1000, rA, 64'h4,
      64'h8000000000000014, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h0020F2B3, 64'h1000, rA, 64'h4,
      64'h0, yes, zero64, memNone, no, 64'h1004, no, no},
    // addi -5, srai by 40, lui, auipc
    '{32'hFFB08293, 64'h1000, 64'h64, zero64,
      64'h5F, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h4280D293, 64'h1000, 64'h8000000000000000, zero64,
      64'hFFFFFFFFFF800000, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h800002B7, 64'h1000, zero64, zero64,
      64'hFFFFFFFF80000000, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h00001297, 64'h1000, zero64, zero64,
      64'h2000, yes, zero64, memNone, no, 64'h1004, no, no},
    // addw, subw, sllw, sraw, addiw
    '{32'h002082BB, 64'h1000, 64'h7FFFFFFF, 64'h1,
      64'hFFFFFFFF80000000, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h402082BB, 64'h1000, zero64, 64'h1,
      negOne, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h002092BB, 64'h1000, 64'h1, 64'h3F,
      64'hFFFFFFFF80000000, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h4020D2BB, 64'h1000, 64'h80000000, 64'h4,
      64'hFFFFFFFFF8000000, yes, zero64, memNone, no, 64'h1004, no, no},
    '{32'h0010829B, 64'h1000, 64'h7FFFFFFF, zero64,
      64'hFFFFFFFF80000000, yes, zero64, memNone, no, 64'h1004, no, no},
    // branches by +16, taken then not taken
    '{32'h00208863, 64'h2000, 64'h5, 64'h5,
      zero64, no, zero64, memNone, no, 64'h2010, yes, no},
    '{32'h00208863, 64'h2000, 64'h5, 64'h6,
      zero64, no, zero64, memNone, no, 64'h2004, no, no},
    '{32'h00209863, 64'h2000, 64'h5, 64'h6,
      zero64, no, zero64, memNone, no, 64'h2010, yes, no},
    '{32'h00209863, 64'h2000, 64'h5, 64'h5,
      zero64, no, zero64, memNone, no, 64'h2004, no, no},
    '{32'h0020C863, 64'h2000, negOne, 64'h1,
      zero64, no, zero64, memNone, no, 64'h2010, yes, no},
    '{32'h0020C863, 64'h2000, 64'h1, negOne,
      zero64, no, zero64, memNone, no, 64'h2004, no, no},
    '{32'h0020D863, 64'h2000, 64'h1, negOne,
      zero64, no, zero64, memNone, no, 64'h2010, yes, no},
    '{32'h0020D863, 64'h2000, negOne, 64'h1,
      zero64, no, zero64, memNone, no, 64'h2004, no, no},
    '{32'h0020E863, 64'h2000, 64'h1, negOne,
      zero64, no, zero64, memNone, no, 64'h2010, yes, no},
    '{32'h0020E863, 64'h2000, negOne, 64'h1,
      zero64, no, zero64, memNone, no, 64'h2004, no, no},
    '{32'h0020F863, 64'h2000, negOne, 64'h1,
      zero64, no, zero64, memNone, no, 64'h2010, yes, no},
    '{32'h0020F863, 64'h2000, 64'h1, negOne,
      zero64, no, zero64, memNone, no, 64'h2004, no, no},
    // jal +0x100, jalr 5(rs1)
    '{32'h100002EF, 64'h3000, zero64, zero64,
      64'h3004, yes, zero64, memNone, no, 64'h3100, yes, no},
    '{32'h005082E7, 64'h3000, 64'h4000, zero64,
      64'h3004, yes, zero64, memNone, no, 64'h4004, yes, no},
    // ld, lbu, sd, sw
    '{32'hFF80B283, 64'h1000, 64'h1000, zero64,
      zero64, yes, 64'hFF8, memD, no, 64'h1004, no, no},
    '{32'h0030C283, 64'h1000, 64'h2000, zero64,
      zero64, yes, 64'h2003, memBu, no, 64'h1004, no, no},
    '{32'h0020B823, 64'h1000, 64'h1000, 64'hDEADBEEFCAFEF00D,
      zero64, no, 64'h1010, memD, yes, 64'h1004, no, no},
    '{32'hFE20AE23, 64'h1000, 64'h100, 64'h12345678,
      zero64, no, 64'hFC, memW, yes, 64'h1004, no, no},
    // unknown opcode, then an M-extension encoding
    '{32'hFFFFFFFF, 64'h1000, 64'h7, 64'h9,
      zero64, no, zero64, memNone, no, 64'h1004, no, yes},
    '{32'h022082B3, 64'h1000, 64'h7, 64'h9,
      zero64, no, zero64, memNone, no, 64'h1004, no, yes}
};

`endif

/* bench/rvExecUnitTb.sv */
module rvExecUnitTb;
    import isaPkg::*;
    import pipePkg::*;

    `include "tbVectors.svh"

    localparam int OutCredits = 4;
    localparam int Timeout    = 300;

    logic      clk;
    logic      arstN;
    logic      inValid;
    logic      inReady;
    issuePktT  inPkt;
    logic      creditReturn;
    logic      outValid;
    resultPktT outPkt;

    int seed = 32'hd45d91f3;
    int rxCount = 0;
    int sentCount = 0;
    int returnedCount = 0; // returns already applied by the DUT
    int issuedReturns = 0;

    rvExecUnit #(
        .OutCredits (OutCredits)
    ) rvExecUnit_inst (
        .clk          (clk),
        .arstN        (arstN),
        .inValid      (inValid),
        .inReady      (inReady),
        .inPkt        (inPkt),
        .creditReturn (creditReturn),
        .outValid     (outValid),
        .outPkt       (outPkt)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input xlenT got, input xlenT exp);
        if (got !== exp) begin
            failRun($sformatf("Error: %s got %h expected %h (row %0d)",
                              name, got, exp, rxCount));
        end
    endtask

    task automatic comparePacket(input vecT v);
        checkValue("wbEn", xlenT'(outPkt.wbEn), xlenT'(v.wbEn));
        if (v.wbEn && v.memOp == memNone) begin // load data is not known here
            checkValue("wbData", outPkt.wbData, v.wbData);
        end
        if (v.wbEn) begin
            checkValue("rd", xlenT'(outPkt.rd), 64'd5);
        end
        if (v.memOp != memNone) begin
            checkValue("memAddr", outPkt.memAddr, v.memAddr);
        end
        checkValue("memOp", xlenT'(outPkt.memOp), xlenT'(v.memOp));
        checkValue("memWr", xlenT'(outPkt.memWr), xlenT'(v.memWr));
        checkValue("storeData", outPkt.storeData, v.memWr ? v.rs2Val : zero64);
        checkValue("nextPc", outPkt.nextPc, v.nextPc);
        checkValue("branchTaken", xlenT'(outPkt.branchTaken), xlenT'(v.taken));
        checkValue("illegal", xlenT'(outPkt.illegal), xlenT'(v.illegal));
    endtask

    // consumer side, sampled at the falling edge where everything is settled
    always @(negedge clk) begin
        if (arstN && outValid) begin
            if (sentCount >= OutCredits + returnedCount) begin
                failRun("outValid raised with no credit left");
            end
            if (rxCount >= NumVecs) begin
                failRun("more packets came out than were sent in");
            end
            comparePacket(vecTable[rxCount]);
            rxCount++;
            sentCount++;
        end
        if (arstN && creditReturn) begin
            returnedCount++;
        end
    end

    // frees consumer slots after a random delay
    initial begin
        int gap;
        creditReturn = 1'b0;
        gap = 0;
        forever begin
            @(posedge clk);
            #1;
            creditReturn = 1'b0;
            if (sentCount > issuedReturns) begin
                if (gap == 0) begin
                    creditReturn = 1'b1;
                    issuedReturns++;
                    gap = $unsigned($random(seed)) % 7;
                end else begin
                    gap--;
                end
            end
        end
    end

    initial begin
        int waitCnt;
        arstN   = 1'b0;
        inValid = 1'b0;
        inPkt   = '0;
        repeat (5) @(posedge clk);
        if (inReady !== 1'b0 || outValid !== 1'b0) begin
            failRun("inReady or outValid high during reset");
        end
        #1;
        arstN = 1'b1;

        for (int i = 0; i < NumVecs; i++) begin
            inValid = 1'b1;
            inPkt   = '{pc: vecTable[i].pc, inst: vecTable[i].inst,
                        rs1Val: vecTable[i].rs1Val, rs2Val: vecTable[i].rs2Val};
            waitCnt = 0;
            @(negedge clk);
            while (inReady !== 1'b1) begin
                waitCnt++;
                if (waitCnt > Timeout) begin
                    failRun($sformatf("timed out waiting for inReady at row %0d", i));
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            inValid = 1'b0; // idle gap between some rows
            if ($unsigned($random(seed)) % 4 == 0) begin
                @(posedge clk);
                #1;
            end
        end
        inValid = 1'b0;

        waitCnt = 0;
        while (rxCount < NumVecs) begin
            waitCnt++;
            if (waitCnt > Timeout) begin
                failRun("timed out waiting for the last result packets");
            end
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+bench
design/isaPkg.sv
design/pipePkg.sv
design/instDecoder.sv
design/aluExec.sv
design/resultStage.sv
design/rvExecUnit.sv
bench/rvExecUnitTb.sv

/* Makefile */
TOP       ?= rvExecUnitTb
SRC       ?= src.f
OBJDIR    ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(SRC)

$(OBJDIR)/V$(TOP): $(SRC)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(SRC)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
